//--- source/dbg_harness_pkg.sv
// ------------------------------------------------------------------------
// debug harness package
// DMI widths, register map, op and response codes, delay window and the
// request, response and DMCONTROL structs shared across the debug path
// ------------------------------------------------------------------------

`default_nettype none

package dbg_harness_pkg;

  localparam int unsigned DmiAddrWidth = 7;
  localparam int unsigned DmiDataWidth = 32;

  // core debug request blocked for this many cycles after power-on reset
  localparam int unsigned DebugDelCycles = 500;
  localparam int unsigned DebugCntWidth  = $clog2(DebugDelCycles + 1);

  typedef logic [DebugCntWidth-1:0] dbg_cnt_t;

  // register map
  localparam logic [DmiAddrWidth-1:0] AddrData0     = 7'h04;
  localparam logic [DmiAddrWidth-1:0] AddrDmControl = 7'h10;
  localparam logic [DmiAddrWidth-1:0] AddrExit      = 7'h20;

  // value 3 is reserved
  typedef enum logic [1:0] {
    OpNop   = 2'd0,
    OpRead  = 2'd1,
    OpWrite = 2'd2
  } dtm_op_e;

  typedef enum logic [1:0] {
    RespSuccess = 2'd0,
    RespFailed  = 2'd2
  } dmi_resp_code_e;

  typedef struct packed {
    logic [DmiAddrWidth-1:0] addr;
    dtm_op_e                 op;
    logic [DmiDataWidth-1:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic [DmiDataWidth-1:0] data;
    dmi_resp_code_e          resp;
  } dmi_resp_t;

  // bits 31, 1 and 0 of DMCONTROL
  typedef struct packed {
    logic haltreq;
    logic ndmreset;
    logic dmactive;
  } dmcontrol_t;

endpackage

`default_nettype wire

//--- source/dmi_source_sel.sv
// ------------------------------------------------------------------------
// debug source selector
// steers the JTAG-side or DMI-side request port to the debug module and
// keeps the choice fixed from request acceptance to response acceptance
// ------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module dmi_source_sel (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      src_sel_i,
  input  logic                      jtag_req_valid_i,
  input  logic                      dmi_req_valid_i,
  input  dbg_harness_pkg::dmi_req_t jtag_req_i,
  input  dbg_harness_pkg::dmi_req_t dmi_req_i,
  output logic                      jtag_req_ready_o,
  output logic                      dmi_req_ready_o,
  output logic                      jtag_resp_valid_o,
  output logic                      dmi_resp_valid_o,
  input  logic                      jtag_resp_ready_i,
  input  logic                      dmi_resp_ready_i,
  output logic                      req_valid_o,
  output dbg_harness_pkg::dmi_req_t req_o,
  input  logic                      req_ready_i,
  input  logic                      resp_valid_i,
  output logic                      resp_ready_o
);

  logic sel_q;
  logic busy_q;
  logic req_fire;
  logic resp_fire;

  assign req_fire  = req_valid_o & req_ready_i;
  assign resp_fire = resp_valid_i & resp_ready_o;

  // 1 selects JTAG, 0 selects DMI
  assign req_valid_o       = sel_q ? jtag_req_valid_i : dmi_req_valid_i;
  assign req_o             = sel_q ? jtag_req_i : dmi_req_i;
  assign resp_ready_o      = sel_q ? jtag_resp_ready_i : dmi_resp_ready_i;
  assign jtag_req_ready_o  = sel_q & req_ready_i;
  assign dmi_req_ready_o   = ~sel_q & req_ready_i;
  assign jtag_resp_valid_o = sel_q & resp_valid_i;
  assign dmi_resp_valid_o  = ~sel_q & resp_valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_sel
    if (!rst_ni) begin
      sel_q  <= 1'b0;
      busy_q <= 1'b0;
    end else begin
      if (req_fire) begin
        busy_q <= 1'b1;
      end else if (resp_fire) begin
        busy_q <= 1'b0;
      end
      // pick up a new source only between transactions
      if (!busy_q && !req_fire) begin
        sel_q <= src_sel_i;
      end
    end
  end

  a_sel_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (busy_q || req_fire) |=> $stable(sel_q));

endmodule

`default_nettype wire

//--- source/dm_ctrl_fsm.sv
// ------------------------------------------------------------------------
// debug module controller
// accepts one DMI request at a time, drives the register access and holds
// the response until the source takes it
// ------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module dm_ctrl_fsm (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      req_valid_i,
  input  dbg_harness_pkg::dmi_req_t                 req_i,
  output logic                                      req_ready_o,
  output logic                                      resp_valid_o,
  output dbg_harness_pkg::dmi_resp_t                resp_o,
  input  logic                                      resp_ready_i,
  output logic                                      reg_we_o,
  output logic [dbg_harness_pkg::DmiAddrWidth-1:0]  reg_addr_o,
  output logic [dbg_harness_pkg::DmiDataWidth-1:0]  reg_wdata_o,
  input  logic [dbg_harness_pkg::DmiDataWidth-1:0]  reg_rdata_i,
  input  logic                                      reg_hit_i
);

  typedef enum logic {
    StIdle,
    StResp
  } state_e;

  state_e                     state_q, state_d;
  dbg_harness_pkg::dmi_resp_t resp_q, resp_d;
  logic                       req_fire;

  assign req_ready_o  = (state_q == StIdle);
  assign resp_valid_o = (state_q == StResp);
  assign resp_o       = resp_q;
  assign req_fire     = req_valid_i & req_ready_o;

  assign reg_addr_o  = req_i.addr;
  assign reg_wdata_o = req_i.data;
  assign reg_we_o    = req_fire & (req_i.op == dbg_harness_pkg::OpWrite) & reg_hit_i;

  // ------------------------------------------------------------------------
  // op decode and response
  // ------------------------------------------------------------------------
  always_comb begin : p_decode
    resp_d.data = '0;
    resp_d.resp = dbg_harness_pkg::RespFailed;
    case (req_i.op)
      dbg_harness_pkg::OpNop: begin
        resp_d.resp = dbg_harness_pkg::RespSuccess;
      end
      dbg_harness_pkg::OpRead: begin
        if (reg_hit_i) begin
          resp_d.data = reg_rdata_i;
          resp_d.resp = dbg_harness_pkg::RespSuccess;
        end
      end
      dbg_harness_pkg::OpWrite: begin
        if (reg_hit_i) begin
          resp_d.resp = dbg_harness_pkg::RespSuccess;
        end
      end
      // reserved op or unmapped address
      default: ;
    endcase
  end

  always_comb begin : p_next
    state_d = state_q;
    case (state_q)
      StIdle:  if (req_fire) state_d = StResp;
      StResp:  if (resp_ready_i) state_d = StIdle;
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_resp
    if (!rst_ni) begin
      resp_q <= '0;
    end else if (req_fire) begin
      resp_q <= resp_d;
    end
  end

  a_resp_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (resp_valid_o && !resp_ready_i) |=> (resp_valid_o && $stable(resp_o)));

endmodule

`default_nettype wire

//--- source/dm_regfile.sv
// ------------------------------------------------------------------------
// debug module registers
// DATA0, DMCONTROL and EXIT with address decode and read mux
// ------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module dm_regfile (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     we_i,
  input  logic [dbg_harness_pkg::DmiAddrWidth-1:0] addr_i,
  input  logic [dbg_harness_pkg::DmiDataWidth-1:0] wdata_i,
  output logic [dbg_harness_pkg::DmiDataWidth-1:0] rdata_o,
  output logic                                     hit_o,
  output dbg_harness_pkg::dmcontrol_t              dmcontrol_o,
  output logic [dbg_harness_pkg::DmiDataWidth-1:0] exit_o
);

  logic [dbg_harness_pkg::DmiDataWidth-1:0] data0_q;
  logic [dbg_harness_pkg::DmiDataWidth-1:0] exit_q;
  dbg_harness_pkg::dmcontrol_t              dmcontrol_q;

  assign dmcontrol_o = dmcontrol_q;
  assign exit_o      = exit_q;

  // decode and read data, unused DMCONTROL bits read as zero
  always_comb begin : p_read
    hit_o   = 1'b1;
    rdata_o = '0;
    case (addr_i)
      dbg_harness_pkg::AddrData0:     rdata_o = data0_q;
      dbg_harness_pkg::AddrDmControl: begin
        rdata_o[31] = dmcontrol_q.haltreq;
        rdata_o[1]  = dmcontrol_q.ndmreset;
        rdata_o[0]  = dmcontrol_q.dmactive;
      end
      dbg_harness_pkg::AddrExit:      rdata_o = exit_q;
      default:                        hit_o = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      data0_q     <= '0;
      exit_q      <= '0;
      dmcontrol_q <= '0;
    end else if (we_i) begin
      case (addr_i)
        dbg_harness_pkg::AddrData0:     data0_q <= wdata_i;
        dbg_harness_pkg::AddrDmControl: begin
          dmcontrol_q.haltreq  <= wdata_i[31];
          dmcontrol_q.ndmreset <= wdata_i[1];
          dmcontrol_q.dmactive <= wdata_i[0];
        end
        dbg_harness_pkg::AddrExit:      exit_q <= wdata_i;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/debug_gate_timer.sv
// ------------------------------------------------------------------------
// debug request gate
// holds off the core debug request for a fixed window after power-on
// reset and while debug is disabled
// ------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module debug_gate_timer (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  dbg_harness_pkg::dmcontrol_t dmcontrol_i,
  input  logic                        debug_enable_i,
  output logic                        debug_req_o
);

  dbg_harness_pkg::dbg_cnt_t cnt_q;
  logic                      cnt_done;

  assign cnt_done    = (cnt_q == '0);
  assign debug_req_o = cnt_done & debug_enable_i &
                       dmcontrol_i.haltreq & dmcontrol_i.dmactive;

  // reload on power-on reset, then count down and stick at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_del_cnt
    if (!rst_ni) begin
      cnt_q <= dbg_harness_pkg::dbg_cnt_t'(dbg_harness_pkg::DebugDelCycles);
    end else if (!cnt_done) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  a_no_early_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cnt_q != '0) |-> !debug_req_o);

endmodule

`default_nettype wire

//--- source/ndm_reset_gen.sv
// ------------------------------------------------------------------------
// core reset generator
// power-on reset or non-debug reset asserts at once, release goes
// through a two-flop synchronizer
// ------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module ndm_reset_gen (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  dbg_harness_pkg::dmcontrol_t dmcontrol_i,
  output logic                        core_rst_no
);

  logic       comb_rst_n;
  logic [1:0] sync_q;

  assign comb_rst_n  = rst_ni & ~dmcontrol_i.ndmreset;
  assign core_rst_no = sync_q[1];

  always_ff @(posedge clk_i or negedge comb_rst_n) begin : p_sync
    if (!comb_rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  a_ndm_holds : assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmcontrol_i.ndmreset |-> !core_rst_no);

endmodule

`default_nettype wire

//--- source/dbg_harness_top.sv
// ------------------------------------------------------------------------
// debug harness top
// two debug sources share one debug module, which drives the core reset,
// the gated debug request and the exit code
// ------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module dbg_harness_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       src_sel_i,
  input  logic                       jtag_req_valid_i,
  input  dbg_harness_pkg::dmi_req_t  jtag_req_i,
  output logic                       jtag_req_ready_o,
  output logic                       jtag_resp_valid_o,
  output dbg_harness_pkg::dmi_resp_t jtag_resp_o,
  input  logic                       jtag_resp_ready_i,
  input  logic                       dmi_req_valid_i,
  input  dbg_harness_pkg::dmi_req_t  dmi_req_i,
  output logic                       dmi_req_ready_o,
  output logic                       dmi_resp_valid_o,
  output dbg_harness_pkg::dmi_resp_t dmi_resp_o,
  input  logic                       dmi_resp_ready_i,
  input  logic                       debug_enable_i,
  output logic                       debug_req_o,
  output logic                       core_rst_no,
  output logic [31:0]                exit_o
);

  dbg_harness_pkg::dmi_req_t                req;
  dbg_harness_pkg::dmi_resp_t               resp;
  dbg_harness_pkg::dmcontrol_t              dmcontrol;
  logic                                     req_valid;
  logic                                     req_ready;
  logic                                     resp_valid;
  logic                                     resp_ready;
  logic                                     reg_we;
  logic                                     reg_hit;
  logic [dbg_harness_pkg::DmiAddrWidth-1:0] reg_addr;
  logic [dbg_harness_pkg::DmiDataWidth-1:0] reg_wdata;
  logic [dbg_harness_pkg::DmiDataWidth-1:0] reg_rdata;

  // response payload goes to both sources, valid is steered
  assign jtag_resp_o = resp;
  assign dmi_resp_o  = resp;

  dmi_source_sel i_source_sel (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .src_sel_i         ( src_sel_i         ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .dmi_req_valid_i   ( dmi_req_valid_i   ),
    .jtag_req_i        ( jtag_req_i        ),
    .dmi_req_i         ( dmi_req_i         ),
    .jtag_req_ready_o  ( jtag_req_ready_o  ),
    .dmi_req_ready_o   ( dmi_req_ready_o   ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .dmi_resp_valid_o  ( dmi_resp_valid_o  ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .dmi_resp_ready_i  ( dmi_resp_ready_i  ),
    .req_valid_o       ( req_valid         ),
    .req_o             ( req               ),
    .req_ready_i       ( req_ready         ),
    .resp_valid_i      ( resp_valid        ),
    .resp_ready_o      ( resp_ready        )
  );

  dm_ctrl_fsm i_ctrl (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .req_valid_i  ( req_valid  ),
    .req_i        ( req        ),
    .req_ready_o  ( req_ready  ),
    .resp_valid_o ( resp_valid ),
    .resp_o       ( resp       ),
    .resp_ready_i ( resp_ready ),
    .reg_we_o     ( reg_we     ),
    .reg_addr_o   ( reg_addr   ),
    .reg_wdata_o  ( reg_wdata  ),
    .reg_rdata_i  ( reg_rdata  ),
    .reg_hit_i    ( reg_hit    )
  );

  dm_regfile i_regfile (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .we_i        ( reg_we    ),
    .addr_i      ( reg_addr  ),
    .wdata_i     ( reg_wdata ),
    .rdata_o     ( reg_rdata ),
    .hit_o       ( reg_hit   ),
    .dmcontrol_o ( dmcontrol ),
    .exit_o      ( exit_o    )
  );

  debug_gate_timer i_gate_timer (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .dmcontrol_i    ( dmcontrol      ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

  ndm_reset_gen i_reset_gen (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .dmcontrol_i ( dmcontrol   ),
    .core_rst_no ( core_rst_no )
  );

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
// ------------------------------------------------------------------------
// testbench clock and reset
// 4 ns clock, active low reset held for 16 cycles
// ------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HalfPeriod  = 2;
  localparam int ResetCycles = 16;

  initial begin : p_clk
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // release on a falling edge, away from the DUT sampling edge
  initial begin : p_rst
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- dv/tb_dbg_harness.sv
// ------------------------------------------------------------------------
// debug harness testbench
// random DMI traffic from both sources with back-pressure, checked
// against a register model, reset and debug request timing
// ------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tb_dbg_harness;

  localparam int ClkPeriod = 4;
  localparam int NumTxn    = 300;
  localparam int MaxStall  = 6;
  // select cycle, accept cycle, stalls and the final response cycle
  localparam int TxnCycles = MaxStall + 3;
  localparam int TimeoutCycles = 16 + 4 + (NumTxn + 1) * TxnCycles +
                                 int'(dbg_harness_pkg::DebugDelCycles) + 100;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       src_sel_i;
  logic                       jtag_req_valid_i;
  logic                       dmi_req_valid_i;
  dbg_harness_pkg::dmi_req_t  jtag_req_i;
  dbg_harness_pkg::dmi_req_t  dmi_req_i;
  logic                       jtag_req_ready_o;
  logic                       dmi_req_ready_o;
  logic                       jtag_resp_valid_o;
  logic                       dmi_resp_valid_o;
  dbg_harness_pkg::dmi_resp_t jtag_resp_o;
  dbg_harness_pkg::dmi_resp_t dmi_resp_o;
  logic                       jtag_resp_ready_i;
  logic                       dmi_resp_ready_i;
  logic                       debug_enable_i;
  logic                       debug_req_o;
  logic                       core_rst_no;
  logic [31:0]                exit_o;

  // register model
  logic [31:0]                 m_data0;
  logic [31:0]                 m_exit;
  dbg_harness_pkg::dmcontrol_t m_dmctrl;
  int                          ndm_edges;
  int                          edge_cnt = 0;
  int                          seed = 42575;

  tb_clk_gen i_clk_gen (
    .clk_o  ( clk_i  ),
    .rst_no ( rst_ni )
  );

  dbg_harness_top dut0 (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .src_sel_i         ( src_sel_i         ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .jtag_req_i        ( jtag_req_i        ),
    .jtag_req_ready_o  ( jtag_req_ready_o  ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .jtag_resp_o       ( jtag_resp_o       ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .dmi_req_valid_i   ( dmi_req_valid_i   ),
    .dmi_req_i         ( dmi_req_i         ),
    .dmi_req_ready_o   ( dmi_req_ready_o   ),
    .dmi_resp_valid_o  ( dmi_resp_valid_o  ),
    .dmi_resp_o        ( dmi_resp_o        ),
    .dmi_resp_ready_i  ( dmi_resp_ready_i  ),
    .debug_enable_i    ( debug_enable_i    ),
    .debug_req_o       ( debug_req_o       ),
    .core_rst_no       ( core_rst_no       ),
    .exit_o            ( exit_o            )
  );

  // rising edges seen since power-on reset release
  always @(posedge clk_i) begin
    if (rst_ni) begin
      edge_cnt <= edge_cnt + 1;
    end
  end

  task automatic compare(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, act, exp);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  // one clock, then the outputs that do not depend on the handshake
  task automatic next_cycle();
    logic exp_dbg;
    @(negedge clk_i);
    exp_dbg = (edge_cnt >= int'(dbg_harness_pkg::DebugDelCycles)) &&
              m_dmctrl.haltreq && m_dmctrl.dmactive && debug_enable_i;
    compare("debug_req_o", 32'(debug_req_o), 32'(exp_dbg));
    compare("exit_o", exit_o, m_exit);
    compare("core_rst_no", 32'(core_rst_no), 32'(ndm_edges >= 2));
    if (!m_dmctrl.ndmreset && ndm_edges < 2) begin
      ndm_edges++;
    end
    debug_enable_i = 1'($random(seed));
  endtask

  task automatic check_ports(input logic sel, input logic exp_rdy, input logic exp_rv);
    compare("jtag_req_ready_o", 32'(jtag_req_ready_o), 32'(sel & exp_rdy));
    compare("dmi_req_ready_o", 32'(dmi_req_ready_o), 32'(~sel & exp_rdy));
    compare("jtag_resp_valid_o", 32'(jtag_resp_valid_o), 32'(sel & exp_rv));
    compare("dmi_resp_valid_o", 32'(dmi_resp_valid_o), 32'(~sel & exp_rv));
  endtask

  function automatic dbg_harness_pkg::dmi_req_t random_req();
    dbg_harness_pkg::dmi_req_t r;
    r.addr = 7'($random(seed));
    case (2'($random(seed)))
      2'd0: r.addr = dbg_harness_pkg::AddrData0;
      2'd1: r.addr = dbg_harness_pkg::AddrDmControl;
      2'd2: r.addr = dbg_harness_pkg::AddrExit;
      default: ;
    endcase
    r.op   = dbg_harness_pkg::dtm_op_e'(2'($random(seed)));
    r.data = $random(seed);
    return r;
  endfunction

  // expected response, then the write lands in the model
  task automatic model_access(input dbg_harness_pkg::dmi_req_t req,
                              output dbg_harness_pkg::dmi_resp_t resp);
    logic        mapped;
    logic [31:0] value;
    mapped = (req.addr == dbg_harness_pkg::AddrData0) ||
             (req.addr == dbg_harness_pkg::AddrDmControl) ||
             (req.addr == dbg_harness_pkg::AddrExit);
    value = '0;
    if (req.addr == dbg_harness_pkg::AddrData0) value = m_data0;
    if (req.addr == dbg_harness_pkg::AddrExit) value = m_exit;
    if (req.addr == dbg_harness_pkg::AddrDmControl) begin
      value = {m_dmctrl.haltreq, 29'd0, m_dmctrl.ndmreset, m_dmctrl.dmactive};
    end
    resp.data = '0;
    resp.resp = dbg_harness_pkg::RespFailed;
    if (req.op == dbg_harness_pkg::OpNop) begin
      resp.resp = dbg_harness_pkg::RespSuccess;
    end else if (req.op == dbg_harness_pkg::OpRead && mapped) begin
      resp.data = value;
      resp.resp = dbg_harness_pkg::RespSuccess;
    end else if (req.op == dbg_harness_pkg::OpWrite && mapped) begin
      resp.resp = dbg_harness_pkg::RespSuccess;
      if (req.addr == dbg_harness_pkg::AddrData0) m_data0 = req.data;
      if (req.addr == dbg_harness_pkg::AddrExit) m_exit = req.data;
      if (req.addr == dbg_harness_pkg::AddrDmControl) begin
        // setting or clearing ndmreset restarts the release count
        if (req.data[1] || m_dmctrl.ndmreset) ndm_edges = 0;
        m_dmctrl.haltreq  = req.data[31];
        m_dmctrl.ndmreset = req.data[1];
        m_dmctrl.dmactive = req.data[0];
      end
    end
  endtask

  task automatic run_txn(input logic sel, input dbg_harness_pkg::dmi_req_t req);
    dbg_harness_pkg::dmi_resp_t exp_resp;
    dbg_harness_pkg::dmi_resp_t act_resp;
    logic                       take;
    int                         waits;
    src_sel_i = sel;
    next_cycle();
    check_ports(sel, 1'b1, 1'b0);
    // the other source offers noise that must be ignored
    jtag_req_valid_i = sel ? 1'b1 : 1'($random(seed));
    dmi_req_valid_i  = sel ? 1'($random(seed)) : 1'b1;
    jtag_req_i       = sel ? req : random_req();
    dmi_req_i        = sel ? random_req() : req;
    // selection moves while the transaction is open
    src_sel_i        = 1'($random(seed));
    model_access(req, exp_resp);
    next_cycle();
    jtag_req_valid_i = 1'b0;
    dmi_req_valid_i  = 1'b0;
    waits = 0;
    take  = 1'b0;
    while (!take) begin
      check_ports(sel, 1'b0, 1'b1);
      act_resp = sel ? jtag_resp_o : dmi_resp_o;
      compare("resp.data", act_resp.data, exp_resp.data);
      compare("resp.resp", 32'(act_resp.resp), 32'(exp_resp.resp));
      take = (waits >= MaxStall) || 1'($random(seed));
      jtag_resp_ready_i = sel ? take : 1'($random(seed));
      dmi_resp_ready_i  = sel ? 1'($random(seed)) : take;
      src_sel_i         = 1'($random(seed));
      waits++;
      next_cycle();
    end
    jtag_resp_ready_i = 1'b0;
    dmi_resp_ready_i  = 1'b0;
  endtask

  initial begin : p_main
    dbg_harness_pkg::dmi_req_t early;
    src_sel_i         = 1'b0;
    jtag_req_valid_i  = 1'b0;
    dmi_req_valid_i   = 1'b0;
    jtag_req_i        = '0;
    dmi_req_i         = '0;
    jtag_resp_ready_i = 1'b0;
    dmi_resp_ready_i  = 1'b0;
    debug_enable_i    = 1'b0;
    m_data0           = '0;
    m_exit            = '0;
    m_dmctrl          = '0;
    ndm_edges         = 1;
    @(posedge rst_ni);
    next_cycle();
    check_ports(1'b0, 1'b1, 1'b0);
    next_cycle();
    // haltreq and dmactive set well inside the delay window
    early.addr = dbg_harness_pkg::AddrDmControl;
    early.op   = dbg_harness_pkg::OpWrite;
    early.data = 32'h8000_0001;
    run_txn(1'b1, early);
    repeat (NumTxn) begin
      run_txn(1'($random(seed)), random_req());
    end
    next_cycle();
    $display("All checks passed");
    $finish;
  end

  initial begin : p_watchdog
    #(TimeoutCycles * ClkPeriod);
    $display("timeout: the test did not finish within the expected time");
    $display("Checks failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

//--- project.f
source/dbg_harness_pkg.sv
source/dmi_source_sel.sv
source/dm_ctrl_fsm.sv
source/dm_regfile.sv
source/debug_gate_timer.sv
source/ndm_reset_gen.sv
source/dbg_harness_top.sv
dv/tb_clk_gen.sv
dv/tb_dbg_harness.sv

//--- run.sh
#!/bin/sh
# Build and run the debug harness testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_dbg_harness \
  -f project.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if grep -q "Checks failed" "$LOG"; then
  exit 1
fi
exit 0
